// ==== bench/drive_motor_asserts.sv ====
module drive_motor_asserts (
	input logic                                      CLOCK_50,
	input logic                                      rst,
	input logic [robot_drive_pkg::NUM_MANEUVERS-1:0] restart,
	input robot_drive_pkg::maneuver_t                maneuver_sel,
	input logic                                      uart_out,
	input logic                                      ready
);

	timeunit 1ns;
	timeprecision 1ps;

	// failures so far, the testbench reads it at the end
	int unsigned assert_fails = 0;

	// at most one sequencer restarted per cycle
	restart_onehot: assert property (@(posedge CLOCK_50) disable iff (rst) $onehot0(restart))
	else
	begin
		$error("restart has more than one bit set");
		assert_fails++;
	end

	// idle sequencer keeps the line high
	ready_line_idle: assert property (@(posedge CLOCK_50) disable iff (rst) ready |-> uart_out)
	else
	begin
		$error("uart_out is low while ready is high");
		assert_fails++;
	end

	valid_maneuver: assert property (@(posedge CLOCK_50) disable iff (rst)
		maneuver_sel inside {robot_drive_pkg::MAN_STOP, robot_drive_pkg::MAN_FORWARD,
			robot_drive_pkg::MAN_REVERSE, robot_drive_pkg::MAN_TURN_LEFT,
			robot_drive_pkg::MAN_TURN_RIGHT_BACK})
	else
	begin
		$error("maneuver_sel holds no valid maneuver");
		assert_fails++;
	end

endmodule

bind drive_motor drive_motor_asserts asserts_inst (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.restart(restart),
	.maneuver_sel(maneuver_sel),
	.uart_out(uart_out),
	.ready(ready)
);

// ==== bench/drive_motor_tb.sv ====
module drive_motor_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// one byte on the wire plus the idle cycle before the next
	localparam int BYTE_CYCLES =
		robot_drive_pkg::UART_FRAME_BITS * robot_drive_pkg::CLKS_PER_BIT + 1;
	localparam int FRAME_CYCLES = 3 * BYTE_CYCLES;
	localparam int WAIT_LIMIT = 2 * FRAME_CYCLES;
	localparam int HALF_BIT = robot_drive_pkg::CLKS_PER_BIT / 2;

	logic                        CLOCK_50;
	logic                        rst;
	robot_drive_pkg::direction_t direction;
	robot_drive_pkg::speed_t     speed;
	logic                        uart_out;
	logic                        ready;

	logic [31:0] lcg_state;
	int          mismatch_count;
	int          failure_count;

	drive_motor UUT (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.direction(direction),
		.speed(speed),
		.uart_out(uart_out),
		.ready(ready)
	);

	// 8 ns clock
	initial
	begin
		CLOCK_50 = 1'b0;
		forever #4 CLOCK_50 = ~CLOCK_50;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// byte 0 straight from the decode table
	function automatic robot_drive_pkg::uart_byte_t expected_code(logic [3:0] dir);
		case (dir)
			4'd1, 4'd3, 4'd8: return 8'hA1;
			4'd2:             return 8'hA3;
			4'd5, 4'd7:       return 8'hA2;
			4'd6:             return 8'hA4;
			default:          return 8'hA0;
		endcase
	endfunction

	// byte 1 is zero for stop
	function automatic robot_drive_pkg::uart_byte_t expected_speed(
		robot_drive_pkg::uart_byte_t code, robot_drive_pkg::speed_t spd);
		if (code == 8'hA0)
			return 8'h00;
		return robot_drive_pkg::uart_byte_t'(spd) * 8'd36;
	endfunction

	task automatic check_byte(input robot_drive_pkg::uart_byte_t actual,
		input robot_drive_pkg::uart_byte_t expected, input string name);
		if (actual !== expected)
		begin
			$display("MISMATCH at %0t ns: %s is %02h, expected %02h", $time, name, actual, expected);
			mismatch_count++;
		end
	endtask

	task automatic check_ready(input logic actual, input logic expected, input string name);
		if (actual !== expected)
		begin
			$display("MISMATCH at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
			mismatch_count++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		failure_count++;
	endtask

	// inputs change on the falling edge only
	task automatic drive_inputs(input logic [3:0] dir, input robot_drive_pkg::speed_t spd);
		@(negedge CLOCK_50);
		direction = robot_drive_pkg::direction_t'(dir);
		speed     = spd;
	endtask

	// wait for a start bit, then sample every bit in its middle
	task automatic capture_byte(output robot_drive_pkg::uart_byte_t data, output logic ok);
		logic prev;
		int   waited;
		prev   = uart_out;
		waited = 0;
		data   = '0;
		ok     = 1'b0;
		@(negedge CLOCK_50);
		while (!(prev === 1'b1 && uart_out === 1'b0) && waited < WAIT_LIMIT)
		begin
			prev = uart_out;
			@(negedge CLOCK_50);
			waited++;
		end
		if (waited >= WAIT_LIMIT)
		begin
			report_failure("no start bit arrived on uart_out");
			return;
		end
		repeat (HALF_BIT) @(negedge CLOCK_50);
		if (uart_out !== 1'b0)
			report_failure("start bit on uart_out ended early");
		for (int i = 0; i < 8; i++)
		begin
			repeat (robot_drive_pkg::CLKS_PER_BIT) @(negedge CLOCK_50);
			data[i] = uart_out;
			check_ready(ready, 1'b0, "ready during frame");
		end
		repeat (robot_drive_pkg::CLKS_PER_BIT) @(negedge CLOCK_50);
		if (uart_out !== 1'b1)
			report_failure("stop bit on uart_out is low");
		ok = 1'b1;
	endtask

	// three bytes, checksum, then ready back high
	task automatic expect_frame(input robot_drive_pkg::uart_byte_t exp0,
		input robot_drive_pkg::uart_byte_t exp1);
		robot_drive_pkg::uart_byte_t got [3];
		logic                        ok;
		int                          waited;
		for (int i = 0; i < 3; i++)
		begin
			capture_byte(got[i], ok);
			if (!ok)
				return;
		end
		check_byte(got[0], exp0, "frame byte 0");
		check_byte(got[1], exp1, "frame byte 1");
		check_byte(got[2], exp0 ^ exp1, "frame byte 2");
		// sampled mid stop bit, ready is due right after it ends
		waited = 0;
		while (ready !== 1'b1 && waited < robot_drive_pkg::CLKS_PER_BIT)
		begin
			@(negedge CLOCK_50);
			waited++;
		end
		if (waited >= robot_drive_pkg::CLKS_PER_BIT)
			report_failure("ready did not rise after the last stop bit");
	endtask

	// no start bit and ready held high for the whole window
	task automatic expect_quiet(input int cycles);
		logic prev;
		prev = uart_out;
		for (int i = 0; i < cycles; i++)
		begin
			@(negedge CLOCK_50);
			if (prev === 1'b1 && uart_out === 1'b0)
			begin
				report_failure("unexpected start bit on uart_out");
				return;
			end
			if (ready !== 1'b1)
			begin
				check_ready(ready, 1'b1, "ready while idle");
				return;
			end
			prev = uart_out;
		end
	endtask

	task automatic test_reset_frame();
		expect_frame(8'hA0, 8'h00);
		// exactly one frame
		expect_quiet(2 * FRAME_CYCLES);
	endtask

	task automatic test_direction_decode();
		robot_drive_pkg::uart_byte_t code;
		robot_drive_pkg::uart_byte_t prev_code;
		// speed change under stop keeps byte 1 at zero
		drive_inputs(4'd0, 3'd2);
		expect_frame(8'hA0, 8'h00);
		prev_code = 8'hA0;
		for (int d = 0; d < 16; d++)
		begin
			code = expected_code(4'(d));
			drive_inputs(4'(d), 3'd2);
			if (code != prev_code)
				expect_frame(code, expected_speed(code, 3'd2));
			else
				expect_quiet(FRAME_CYCLES);
			prev_code = code;
		end
	endtask

	task automatic test_speed_steps();
		robot_drive_pkg::speed_t spd;
		robot_drive_pkg::speed_t next_spd;
		spd = 3'd2;
		drive_inputs(4'd1, spd);
		expect_frame(8'hA1, expected_speed(8'hA1, spd));
		repeat (5)
		begin
			next_spd = robot_drive_pkg::speed_t'(lcg_next() >> 29);
			// a repeated value would send nothing
			if (next_spd == spd)
				next_spd = next_spd + 3'd1;
			spd = next_spd;
			drive_inputs(4'd1, spd);
			expect_frame(8'hA1, expected_speed(8'hA1, spd));
		end
		drive_inputs(4'd9, spd);
		expect_frame(8'hA0, 8'h00);
		drive_inputs(4'd9, spd + 3'd3);
		expect_frame(8'hA0, 8'h00);
	endtask

	task automatic test_no_resend();
		drive_inputs(4'd1, 3'd5);
		expect_frame(8'hA1, expected_speed(8'hA1, 3'd5));
		// same class, same speed
		drive_inputs(4'd3, 3'd5);
		expect_quiet(2 * FRAME_CYCLES);
		drive_inputs(4'd8, 3'd5);
		expect_quiet(2 * FRAME_CYCLES);
	endtask

	task automatic test_ready_in_frame();
		int waited;
		drive_inputs(4'd5, 3'd6);
		waited = 0;
		while (ready !== 1'b0 && waited < 4)
		begin
			@(negedge CLOCK_50);
			waited++;
		end
		if (waited >= 4)
			report_failure("ready did not fall after the restart");
		expect_frame(8'hA2, expected_speed(8'hA2, 3'd6));
	endtask

	initial
	begin
		lcg_state      = 32'h1712_9a1d;
		mismatch_count = 0;
		failure_count  = 0;
		rst            = 1'b1;
		direction      = robot_drive_pkg::IDLE_BASE;
		speed          = 3'd0;
		repeat (4) @(posedge CLOCK_50);
		@(negedge CLOCK_50);
		rst = 1'b0;
		test_reset_frame();
		test_direction_decode();
		test_speed_steps();
		test_no_resend();
		test_ready_in_frame();
		$display("done: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatch_count, failure_count, UUT.asserts_inst.assert_fails);
		if (mismatch_count == 0 && failure_count == 0 && UUT.asserts_inst.assert_fails == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== build.f ====
hdl/robot_drive_pkg.sv
hdl/uart_tx.sv
hdl/maneuver_sequencer.sv
hdl/maneuver_restart.sv
hdl/drive_motor.sv
bench/drive_motor_asserts.sv
bench/drive_motor_tb.sv

// ==== hdl/drive_motor.sv ====
module drive_motor (
	input  logic                        CLOCK_50,
	input  logic                        rst,
	input  robot_drive_pkg::direction_t direction,  // mission state
	input  robot_drive_pkg::speed_t     speed,
	output logic                        uart_out,   // to the motor controller
	output logic                        ready
);

	robot_drive_pkg::maneuver_t                 maneuver_sel;
	logic [robot_drive_pkg::NUM_MANEUVERS-1:0] restart;

	// serial line and ready of each sequencer
	logic stop_uart_out, stop_ready;
	logic forward_uart_out, forward_ready;
	logic reverse_uart_out, reverse_ready;
	logic turn_left_uart_out, turn_left_ready;
	logic right_back_uart_out, right_back_ready;

	// change detect and restart pulses
	maneuver_restart restart_ctrl (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.direction(direction),
		.speed(speed),
		.maneuver_sel(maneuver_sel),
		.restart(restart)
	);

	maneuver_sequencer #(.MANEUVER(robot_drive_pkg::MAN_STOP)) stop_seq (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.restart(restart[robot_drive_pkg::MAN_STOP]),
		.speed(speed),
		.uart_out(stop_uart_out),
		.ready(stop_ready)
	);

	maneuver_sequencer #(.MANEUVER(robot_drive_pkg::MAN_FORWARD)) forward_seq (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.restart(restart[robot_drive_pkg::MAN_FORWARD]),
		.speed(speed),
		.uart_out(forward_uart_out),
		.ready(forward_ready)
	);

	maneuver_sequencer #(.MANEUVER(robot_drive_pkg::MAN_REVERSE)) reverse_seq (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.restart(restart[robot_drive_pkg::MAN_REVERSE]),
		.speed(speed),
		.uart_out(reverse_uart_out),
		.ready(reverse_ready)
	);

	maneuver_sequencer #(.MANEUVER(robot_drive_pkg::MAN_TURN_LEFT)) turn_left_seq (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.restart(restart[robot_drive_pkg::MAN_TURN_LEFT]),
		.speed(speed),
		.uart_out(turn_left_uart_out),
		.ready(turn_left_ready)
	);

	maneuver_sequencer #(.MANEUVER(robot_drive_pkg::MAN_TURN_RIGHT_BACK)) right_back_seq (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.restart(restart[robot_drive_pkg::MAN_TURN_RIGHT_BACK]),
		.speed(speed),
		.uart_out(right_back_uart_out),
		.ready(right_back_ready)
	);

	// route the active maneuver to the outputs
	// switches with the registered maneuver, not the raw direction
	always_comb
	begin
		case (maneuver_sel)
			robot_drive_pkg::MAN_FORWARD:
			begin
				uart_out = forward_uart_out;
				ready    = forward_ready;
			end
			robot_drive_pkg::MAN_REVERSE:
			begin
				uart_out = reverse_uart_out;
				ready    = reverse_ready;
			end
			robot_drive_pkg::MAN_TURN_LEFT:
			begin
				uart_out = turn_left_uart_out;
				ready    = turn_left_ready;
			end
			robot_drive_pkg::MAN_TURN_RIGHT_BACK:
			begin
				uart_out = right_back_uart_out;
				ready    = right_back_ready;
			end
			default:
			begin
				uart_out = stop_uart_out;
				ready    = stop_ready;
			end
		endcase
	end

endmodule

// ==== hdl/maneuver_restart.sv ====
module maneuver_restart (
	input  logic                                       CLOCK_50,
	input  logic                                       rst,
	input  robot_drive_pkg::direction_t                direction,
	input  robot_drive_pkg::speed_t                    speed,
	output robot_drive_pkg::maneuver_t                 maneuver_sel,
	output logic [robot_drive_pkg::NUM_MANEUVERS-1:0] restart
);

	robot_drive_pkg::maneuver_t maneuver_dec;

	// last speed sent
	robot_drive_pkg::speed_t speed_q;

	// set in reset, forces one frame afterwards
	logic first_q;

	logic changed;

	// fold the mission states into maneuvers
	always_comb
	begin
		case (direction)
			robot_drive_pkg::FORWARDS,
			robot_drive_pkg::TO_TABLE,
			robot_drive_pkg::TO_FACE:
				maneuver_dec = robot_drive_pkg::MAN_FORWARD;
			robot_drive_pkg::TURN:
				maneuver_dec = robot_drive_pkg::MAN_TURN_LEFT;
			robot_drive_pkg::BACKWARDS,
			robot_drive_pkg::RETURN_HOME:
				maneuver_dec = robot_drive_pkg::MAN_REVERSE;
			robot_drive_pkg::TURN_BACK:
				maneuver_dec = robot_drive_pkg::MAN_TURN_RIGHT_BACK;
			// idle states, stop and unused codes
			default:
				maneuver_dec = robot_drive_pkg::MAN_STOP;
		endcase
	end

	assign changed = first_q || (maneuver_dec != maneuver_sel) || (speed != speed_q);

	// restart lands in the same cycle as the new maneuver_sel
	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			maneuver_sel <= robot_drive_pkg::MAN_STOP;
			speed_q      <= '0;
			first_q      <= 1'b1;
			restart      <= '0;
		end
		else
		begin
			maneuver_sel <= maneuver_dec;
			speed_q      <= speed;
			first_q      <= 1'b0;
			restart      <= '0;
			// one-hot pulse for the new maneuver only
			if (changed)
				restart[maneuver_dec] <= 1'b1;
		end
	end

endmodule

// ==== hdl/maneuver_sequencer.sv ====
module maneuver_sequencer #(
	parameter robot_drive_pkg::maneuver_t MANEUVER = robot_drive_pkg::MAN_STOP
) (
	input  logic                    CLOCK_50,
	input  logic                    rst,
	input  logic                    restart,
	input  robot_drive_pkg::speed_t speed,
	output logic                    uart_out,
	output logic                    ready
);

	typedef enum logic {
		SEQ_IDLE,
		SEQ_WAIT
	} seq_state_t;

	// byte 0 of the frame for this maneuver
	function automatic robot_drive_pkg::uart_byte_t frame_code(robot_drive_pkg::maneuver_t m);
		case (m)
			robot_drive_pkg::MAN_FORWARD:         return robot_drive_pkg::FRAME_CODE_FORWARD;
			robot_drive_pkg::MAN_REVERSE:         return robot_drive_pkg::FRAME_CODE_REVERSE;
			robot_drive_pkg::MAN_TURN_LEFT:       return robot_drive_pkg::FRAME_CODE_TURN_LEFT;
			robot_drive_pkg::MAN_TURN_RIGHT_BACK: return robot_drive_pkg::FRAME_CODE_TURN_RIGHT_BACK;
			default:                              return robot_drive_pkg::FRAME_CODE_STOP;
		endcase
	endfunction

	seq_state_t state;
	logic [1:0] byte_idx;
	logic [1:0] next_idx;

	// speed captured at restart
	robot_drive_pkg::speed_t speed_q;

	robot_drive_pkg::uart_byte_t byte0;
	robot_drive_pkg::uart_byte_t byte1;
	robot_drive_pkg::uart_byte_t byte2;

	logic                        tx_start;
	robot_drive_pkg::uart_byte_t tx_data;
	logic                        tx_busy;

	// frame bytes
	assign byte0 = frame_code(MANEUVER);
	// stop never carries a speed
	assign byte1 = (MANEUVER == robot_drive_pkg::MAN_STOP) ? 8'd0 :
		robot_drive_pkg::uart_byte_t'(speed_q) * robot_drive_pkg::SPEED_STEP;
	// simple checksum
	assign byte2 = byte0 ^ byte1;

	// restart goes straight to the transmitter so the start bit follows next cycle
	assign tx_start = restart ||
		(state == SEQ_WAIT && !tx_busy && byte_idx != 2'd2);
	assign next_idx = restart ? 2'd0 : byte_idx + 2'd1;

	always_comb
	begin
		case (next_idx)
			2'd0:    tx_data = byte0;
			2'd1:    tx_data = byte1;
			default: tx_data = byte2;
		endcase
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			state    <= SEQ_IDLE;
			byte_idx <= 2'd0;
		end
		else if (restart)
		begin
			// start over at byte 0 even mid-frame
			state    <= SEQ_WAIT;
			byte_idx <= 2'd0;
		end
		else if (state == SEQ_WAIT && !tx_busy)
		begin
			// busy just fell, move on or finish
			if (byte_idx == 2'd2)
				state <= SEQ_IDLE;
			else
				byte_idx <= next_idx;
		end
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (restart)
			speed_q <= speed;
	end

	// low from the restart cycle until the last stop bit is out
	assign ready = (state == SEQ_IDLE) && !restart;

	uart_tx tx_unit (
		.CLOCK_50(CLOCK_50),
		.rst(rst),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.tx(uart_out),
		.tx_busy(tx_busy)
	);

endmodule

// ==== hdl/robot_drive_pkg.sv ====
package robot_drive_pkg;

	// mission states from the robot FSM
	// codes 10 to 15 are never produced and decode as stop
	typedef enum logic [3:0] {
		IDLE_BASE   = 4'd0,
		FORWARDS    = 4'd1,
		TURN        = 4'd2,
		TO_TABLE    = 4'd3,
		IDLE_TABLE  = 4'd4,
		BACKWARDS   = 4'd5,
		TURN_BACK   = 4'd6,
		RETURN_HOME = 4'd7,
		TO_FACE     = 4'd8,
		STOP        = 4'd9
	} direction_t;

	// motor maneuvers, one sequencer each
	typedef enum logic [2:0] {
		MAN_STOP            = 3'd0,
		MAN_FORWARD         = 3'd1,
		MAN_REVERSE         = 3'd2,
		MAN_TURN_LEFT       = 3'd3,
		MAN_TURN_RIGHT_BACK = 3'd4
	} maneuver_t;

	// width of the restart vector
	localparam int NUM_MANEUVERS = 5;

	// one byte on the serial line
	typedef logic [7:0] uart_byte_t;

	// speed level from the mission FSM
	typedef logic [2:0] speed_t;

	// short bit time so simulation stays fast
	localparam int CLKS_PER_BIT = 8;
	localparam int BAUD_CNT_W = $clog2(CLKS_PER_BIT);

	// start bit, eight data bits, stop bit
	localparam int UART_FRAME_BITS = 10;

	// byte 0 of each command frame
	localparam uart_byte_t FRAME_CODE_STOP            = 8'hA0;
	localparam uart_byte_t FRAME_CODE_FORWARD         = 8'hA1;
	localparam uart_byte_t FRAME_CODE_REVERSE         = 8'hA2;
	localparam uart_byte_t FRAME_CODE_TURN_LEFT       = 8'hA3;
	localparam uart_byte_t FRAME_CODE_TURN_RIGHT_BACK = 8'hA4;

	// byte 1 is speed times this step, 7 * 36 still fits a byte
	localparam uart_byte_t SPEED_STEP = 8'd36;

endpackage

// ==== hdl/uart_tx.sv ====
module uart_tx (
	input  logic                        CLOCK_50,
	input  logic                        rst,
	input  logic                        tx_start,
	input  robot_drive_pkg::uart_byte_t tx_data,
	output logic                        tx,
	output logic                        tx_busy
);

	// start, data and stop bits, shifted out from bit 0
	logic [robot_drive_pkg::UART_FRAME_BITS-1:0] shift_q;

	// clocks spent in the current bit
	logic [robot_drive_pkg::BAUD_CNT_W-1:0] baud_cnt;

	// index of the bit on the line, 0 is the start bit
	logic [3:0] bit_cnt;

	logic busy_q;
	logic baud_tick;

	// last clock of the current bit
	assign baud_tick = (baud_cnt == robot_drive_pkg::BAUD_CNT_W'(robot_drive_pkg::CLKS_PER_BIT - 1));

	// control counters
	always_ff @(posedge CLOCK_50)
	begin
		if (rst)
		begin
			busy_q   <= 1'b0;
			baud_cnt <= '0;
			bit_cnt  <= '0;
		end
		else if (tx_start)
		begin
			// a new start drops whatever was in flight
			busy_q   <= 1'b1;
			baud_cnt <= '0;
			bit_cnt  <= '0;
		end
		else if (busy_q)
		begin
			if (baud_tick)
			begin
				baud_cnt <= '0;
				if (bit_cnt == 4'(robot_drive_pkg::UART_FRAME_BITS - 1))
				begin
					// stop bit done
					busy_q <= 1'b0;
				end
				else
				begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
			else
			begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	// payload shift register, stop bit in the MSB
	always_ff @(posedge CLOCK_50)
	begin
		if (tx_start)
			shift_q <= {1'b1, tx_data, 1'b0};
		else if (busy_q && baud_tick)
			shift_q <= {1'b1, shift_q[robot_drive_pkg::UART_FRAME_BITS-1:1]};
	end

	// line idles high between transfers
	assign tx      = busy_q ? shift_q[0] : 1'b1;
	assign tx_busy = busy_q;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the drive_motor testbench with Verilator
# the run counts as failed when the log holds the fail message

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
	--top-module drive_motor_tb --Mdir obj_dir -o drive_motor_sim \
	-f build.f \
	&& ./obj_dir/drive_motor_sim +verilator+error+limit+100 > "$LOG" 2>&1 \
	|| { cat "$LOG" 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat "$LOG"
grep -qF '** FAIL **' "$LOG" && { echo "simulation failed"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }
